//--- common/y86Pkg.sv
`include "y86_cfg.svh"

package y86Pkg;

	typedef logic [`WORD_WIDTH-1:0] word;
	typedef logic [3:0] regId;
	typedef logic [3:0] fnCode;

	typedef enum logic [3:0] {
		icHalt   = 4'h0,
		icNop    = 4'h1,
		icRrmovq = 4'h2,
		icIrmovq = 4'h3,
		icRmmovq = 4'h4,
		icMrmovq = 4'h5,
		icOpq    = 4'h6,
		icJxx    = 4'h7,
		icCall   = 4'h8,
		icRet    = 4'h9,
		icPushq  = 4'hA,
		icPopq   = 4'hB
	} icodeE;

	typedef struct packed {
		logic zf;
		logic sf;
		logic of;
	} condCodes;

	// valM carries the data memory read, which lives outside this block
	typedef struct packed {
		icodeE icode;
		fnCode ifun;
		regId  rA;
		regId  rB;
		word   valC;
		word   valM;
	} instrRec;

	typedef struct packed {
		icodeE icode;
		logic  cnd;
		word   valE;
		word   valA;
	} resultRec;

endpackage

//--- common/y86_cfg.svh
`ifndef Y86_CFG_SVH
`define Y86_CFG_SVH

// the Y86-64 ISA fixes the data path at 64 bits
`define WORD_WIDTH 64

// program registers %rax through %r14
`define NUM_REGS 15

// stack pointer register ID
`define REG_RSP 4'h4

// ID that selects no register at all
`define REG_NONE 4'hF

`endif

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing -f vlog.f --top-module y86Tb -Mdir build/obj

./build/obj/Vy86Tb > build/sim.log
cat build/sim.log

if grep -q "Test failures found" build/sim.log; then
	echo "simulation reported errors"
	exit 1
fi
echo "simulation finished cleanly"

//--- test/y86Checker.sv
`include "y86_cfg.svh"

module y86Checker (
	input  logic             clk,
	input  logic             rstN,
	input  logic             inValid,
	input  logic             inReady,
	input  y86Pkg::instrRec  inInstr,
	input  logic             outValid,
	input  logic             outReady,
	input  y86Pkg::resultRec outResult,
	output int               errorCount,
	output int               resultCount,
	output int               pendingCount
);

	timeunit 1ns;
	timeprecision 1ps;

	y86Pkg::word      modelRegs [`NUM_REGS];
	y86Pkg::condCodes modelFlags;
	y86Pkg::resultRec expQ [$];
	logic             afterReset;
	logic             holdPending;
	y86Pkg::resultRec heldResult;

	initial begin
		errorCount   = 0;
		resultCount  = 0;
		pendingCount = 0;
		afterReset   = 1'b0;
		holdPending  = 1'b0;
	end

	function automatic y86Pkg::word readReg(input y86Pkg::regId id);
		if (id == `REG_NONE) begin
			return '0;
		end
		return modelRegs[id];
	endfunction

	function automatic logic condHolds(input y86Pkg::fnCode fn);
		logic lt;
		lt = modelFlags.sf ^ modelFlags.of;
		case (fn)
			4'h0:    return 1'b1;
			4'h1:    return lt | modelFlags.zf;
			4'h2:    return lt;
			4'h3:    return modelFlags.zf;
			4'h4:    return !modelFlags.zf;
			4'h5:    return !lt;
			4'h6:    return !lt && !modelFlags.zf;
			default: return 1'b0;
		endcase
	endfunction

	// runs one instruction on the model in program order and queues its result
	task automatic modelStep(input y86Pkg::instrRec ins);
		y86Pkg::regId              dE;
		y86Pkg::regId              dM;
		y86Pkg::word               a;
		y86Pkg::word               b;
		y86Pkg::word               e;
		logic                      c;
		logic signed [`WORD_WIDTH:0] wide;
		dE = `REG_NONE;
		dM = `REG_NONE;
		a  = '0;
		e  = '0;
		c  = condHolds(ins.ifun);
		case (ins.icode)
			y86Pkg::icIrmovq: begin
				e  = ins.valC;
				dE = ins.rB;
			end
			y86Pkg::icRrmovq: begin
				a = readReg(ins.rA);
				e = a;
				if (c) begin
					dE = ins.rB;
				end
			end
			y86Pkg::icRmmovq: begin
				a = readReg(ins.rA);
				e = readReg(ins.rB) + ins.valC;
			end
			y86Pkg::icMrmovq: begin
				e  = readReg(ins.rB) + ins.valC;
				dM = ins.rA;
			end
			y86Pkg::icOpq: begin
				a = readReg(ins.rA);
				b = readReg(ins.rB);
				case (ins.ifun)
					4'h1:    wide = {b[`WORD_WIDTH-1], b} - {a[`WORD_WIDTH-1], a};
					4'h2:    wide = {1'b0, b & a};
					4'h3:    wide = {1'b0, b ^ a};
					default: wide = {b[`WORD_WIDTH-1], b} + {a[`WORD_WIDTH-1], a};
				endcase
				e  = wide[`WORD_WIDTH-1:0];
				dE = ins.rB;
				modelFlags.zf = (e == '0);
				modelFlags.sf = e[`WORD_WIDTH-1];
				// signed overflow shows up as a disagreement of the two top bits
				modelFlags.of = (ins.ifun != 4'h2) && (ins.ifun != 4'h3) &&
					(wide[`WORD_WIDTH] != wide[`WORD_WIDTH-1]);
			end
			y86Pkg::icCall: begin
				e  = readReg(`REG_RSP) - 64'd8;
				dE = `REG_RSP;
			end
			y86Pkg::icPushq: begin
				a  = readReg(ins.rA);
				e  = readReg(`REG_RSP) - 64'd8;
				dE = `REG_RSP;
			end
			y86Pkg::icRet,
			y86Pkg::icPopq: begin
				a  = readReg(`REG_RSP);
				e  = a + 64'd8;
				dE = `REG_RSP;
				if (ins.icode == y86Pkg::icPopq) begin
					dM = ins.rA;
				end
			end
			default: begin
			end
		endcase
		if (dE != `REG_NONE) begin
			modelRegs[dE] = e;
		end
		if (dM != `REG_NONE) begin
			modelRegs[dM] = ins.valM;
		end
		expQ.push_back('{icode: ins.icode, cnd: c, valE: e, valA: a});
	endtask

	task automatic compareResult(input y86Pkg::resultRec got);
		y86Pkg::resultRec exp;
		logic             hasValE;
		if (expQ.size() == 0) begin
			$display("Error at %0t: a result came out with no instruction pending", $time);
			errorCount++;
			return;
		end
		exp = expQ.pop_front();
		resultCount++;
		hasValE = !(exp.icode inside {y86Pkg::icHalt, y86Pkg::icNop, y86Pkg::icJxx});
		if (got.icode !== exp.icode) begin
			$display("Mismatch at %0t: icode %0h, expected %0h", $time, got.icode, exp.icode);
			errorCount++;
		end
		if (got.valA !== exp.valA) begin
			$display("Mismatch at %0t: icode %0h valA %h, expected %h",
				$time, exp.icode, got.valA, exp.valA);
			errorCount++;
		end
		if (hasValE && got.valE !== exp.valE) begin
			$display("Mismatch at %0t: icode %0h valE %h, expected %h",
				$time, exp.icode, got.valE, exp.valE);
			errorCount++;
		end
		if ((exp.icode == y86Pkg::icJxx || exp.icode == y86Pkg::icRrmovq) &&
			got.cnd !== exp.cnd) begin
			$display("Mismatch at %0t: icode %0h cnd %b, expected %b",
				$time, exp.icode, got.cnd, exp.cnd);
			errorCount++;
		end
	endtask

	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				modelRegs[i] = '0;
			end
			modelFlags  = '{zf: 1'b1, sf: 1'b0, of: 1'b0};
			afterReset  = 1'b1;
			holdPending = 1'b0;
			expQ.delete();
		end else begin
			if (afterReset && (outValid !== 1'b0 || inReady !== 1'b1)) begin
				$display("Error at %0t: after reset outValid should be low and inReady high",
					$time);
				errorCount++;
			end
			afterReset = 1'b0;
			// a stalled result must stay put until the consumer takes it
			if (holdPending && (outValid !== 1'b1 || outResult !== heldResult)) begin
				$display("Error at %0t: stalled output changed before it was taken", $time);
				errorCount++;
			end
			holdPending = outValid && !outReady;
			heldResult  = outResult;
			if (outValid && outReady) begin
				compareResult(outResult);
			end
			if (inValid && inReady) begin
				modelStep(inInstr);
			end
		end
		pendingCount = expQ.size();
	end

endmodule

//--- test/y86Tb.sv
module y86Tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] Seed = 32'h1c04_fa55;
	localparam int NumRandom = 3000;
	localparam int WaitLimit = 200;

	logic             clk;
	logic             rstN;
	logic             inValid;
	logic             inReady;
	y86Pkg::instrRec  inInstr;
	logic             outValid;
	logic             outReady;
	y86Pkg::resultRec outResult;

	int          errorCount;
	int          resultCount;
	int          pendingCount;
	int          sentCount;
	logic        timedOut;
	logic [31:0] stimState;
	logic [31:0] stallState;

	y86DecodeExecute DUT (
		.clk       (clk),
		.rstN      (rstN),
		.inValid   (inValid),
		.inReady   (inReady),
		.inInstr   (inInstr),
		.outValid  (outValid),
		.outReady  (outReady),
		.outResult (outResult)
	);

	y86Checker uChecker (
		.clk          (clk),
		.rstN         (rstN),
		.inValid      (inValid),
		.inReady      (inReady),
		.inInstr      (inInstr),
		.outValid     (outValid),
		.outReady     (outReady),
		.outResult    (outResult),
		.errorCount   (errorCount),
		.resultCount  (resultCount),
		.pendingCount (pendingCount)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextStim();
		stimState = xorshift(stimState);
		return stimState;
	endfunction

	function automatic y86Pkg::instrRec makeInstr(input y86Pkg::icodeE icode,
		input y86Pkg::fnCode ifun, input y86Pkg::regId rA, input y86Pkg::regId rB,
		input y86Pkg::word valC, input y86Pkg::word valM);
		y86Pkg::instrRec rec;
		rec.icode = icode;
		rec.ifun  = ifun;
		rec.rA    = rA;
		rec.rB    = rB;
		rec.valC  = valC;
		rec.valM  = valM;
		return rec;
	endfunction

	// irmovq gets the largest share so that registers keep getting fresh values
	function automatic y86Pkg::instrRec randomInstr();
		y86Pkg::instrRec rec;
		logic [31:0]     pick;
		pick      = nextStim();
		rec       = '0;
		rec.rA    = pick[7:4];
		rec.rB    = pick[11:8];
		rec.valC  = {nextStim(), nextStim()};
		rec.valM  = {nextStim(), nextStim()};
		rec.icode = y86Pkg::icIrmovq;
		case (pick[15:12])
			4'h4: rec.icode = y86Pkg::icNop;
			4'h5, 4'h6: begin
				rec.icode = y86Pkg::icRrmovq;
				rec.ifun  = pick[19:16] % 4'd7;
			end
			4'h7, 4'h8: begin
				rec.icode = y86Pkg::icOpq;
				rec.ifun  = {2'b00, pick[17:16]};
			end
			4'h9: begin
				rec.icode = y86Pkg::icJxx;
				rec.ifun  = pick[19:16] % 4'd7;
			end
			4'hA: rec.icode = y86Pkg::icRmmovq;
			4'hB: rec.icode = y86Pkg::icMrmovq;
			4'hC: rec.icode = y86Pkg::icCall;
			4'hD: rec.icode = y86Pkg::icRet;
			4'hE: rec.icode = y86Pkg::icPushq;
			4'hF: rec.icode = y86Pkg::icPopq;
			default: begin
			end
		endcase
		return rec;
	endfunction

	// offers one instruction and returns on the edge it is taken, then maybe idles
	task automatic sendInstr(input y86Pkg::instrRec rec);
		int          waited;
		logic [31:0] gapRand;
		if (timedOut) begin
			return;
		end
		waited  = 0;
		inValid <= 1'b1;
		inInstr <= rec;
		@(posedge clk);
		while (!inReady && !timedOut) begin
			waited++;
			if (waited > WaitLimit) begin
				$display("Timeout: the DUT did not accept an instruction within %0d cycles",
					WaitLimit);
				timedOut = 1'b1;
			end else begin
				@(posedge clk);
			end
		end
		if (!timedOut) begin
			sentCount++;
			gapRand = nextStim();
			if (gapRand[2:0] < 3'd2) begin
				inValid <= 1'b0;
				repeat (int'(gapRand[4:3]) + 1) @(posedge clk);
			end
		end
	endtask

	task automatic drainResults();
		int waited;
		waited = 0;
		@(negedge clk);
		while ((pendingCount != 0 || outValid) && !timedOut) begin
			waited++;
			if (waited > WaitLimit) begin
				$display("Timeout: %0d results were still outstanding when draining ended",
					pendingCount);
				timedOut = 1'b1;
			end else begin
				@(negedge clk);
			end
		end
	endtask

	task automatic endRun();
		logic failed;
		failed = timedOut || (errorCount != 0);
		if (!timedOut && resultCount != sentCount) begin
			$display("Error: %0d results came out for %0d accepted instructions",
				resultCount, sentCount);
			failed = 1'b1;
		end
		$display("Done: %0d instructions sent, %0d results checked, %0d errors, %0d pending",
			sentCount, resultCount, errorCount, pendingCount);
		if (failed) begin
			$display("Test failures found");
		end else begin
			$display("All tests passed!");
		end
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// the consumer stalls on roughly one cycle in four
	initial begin
		outReady   = 1'b0;
		stallState = Seed ^ 32'h9e37_79b9;
		forever begin
			@(posedge clk);
			if (!rstN) begin
				outReady <= 1'b1;
			end else begin
				stallState = xorshift(stallState);
				outReady   <= (stallState[1:0] != 2'b00);
			end
		end
	end

	initial begin
		rstN      = 1'b0;
		inValid   = 1'b0;
		inInstr   = '0;
		timedOut  = 1'b0;
		sentCount = 0;
		stimState = Seed;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;

		for (int r = 0; r < 15; r++) begin
			sendInstr(makeInstr(y86Pkg::icRrmovq, 4'h0, 4'(r), 4'hF, '0, '0));
		end
		for (int f = 0; f < 7; f++) begin
			sendInstr(makeInstr(y86Pkg::icJxx, 4'(f), 4'hF, 4'hF, '0, '0));
		end

		sendInstr(makeInstr(y86Pkg::icIrmovq, 4'h0, 4'hF, 4'h3, 64'h1234_5678_9abc_def0, '0));
		sendInstr(makeInstr(y86Pkg::icRrmovq, 4'h0, 4'h3, 4'h5, '0, '0));
		sendInstr(makeInstr(y86Pkg::icIrmovq, 4'h0, 4'hF, 4'hF, 64'h55aa, '0));
		sendInstr(makeInstr(y86Pkg::icIrmovq, 4'h0, 4'hF, 4'h6, 64'h8000_0000_0000_0000, '0));
		sendInstr(makeInstr(y86Pkg::icIrmovq, 4'h0, 4'hF, 4'h4, 64'h100, '0));
		sendInstr(makeInstr(y86Pkg::icPushq, 4'h0, 4'h3, 4'hF, '0, '0));
		sendInstr(makeInstr(y86Pkg::icCall, 4'h0, 4'hF, 4'hF, 64'h40, '0));
		sendInstr(makeInstr(y86Pkg::icRet, 4'h0, 4'hF, 4'hF, '0, 64'h48));
		sendInstr(makeInstr(y86Pkg::icPopq, 4'h0, 4'h4, 4'hF, '0, 64'hdead_beef));
		sendInstr(makeInstr(y86Pkg::icRrmovq, 4'h0, 4'h4, 4'hF, '0, '0));
		sendInstr(makeInstr(y86Pkg::icMrmovq, 4'h0, 4'h8, 4'h3, 64'h10, 64'h77));
		sendInstr(makeInstr(y86Pkg::icRmmovq, 4'h0, 4'h5, 4'h4, 64'h8, '0));

		for (int f = 0; f < 4; f++) begin
			sendInstr(makeInstr(y86Pkg::icOpq, 4'(f), 4'h6, 4'h5, '0, '0));
			// a fresh marker in %rdi shows whether each conditional move wrote it
			for (int c = 1; c < 7; c++) begin
				sendInstr(makeInstr(y86Pkg::icIrmovq, 4'h0, 4'hF, 4'h7, 64'(c), '0));
				sendInstr(makeInstr(y86Pkg::icRrmovq, 4'(c), 4'h3, 4'h7, '0, '0));
				sendInstr(makeInstr(y86Pkg::icRrmovq, 4'h0, 4'h7, 4'hF, '0, '0));
				sendInstr(makeInstr(y86Pkg::icJxx, 4'(c), 4'hF, 4'hF, '0, '0));
			end
		end

		for (int n = 0; n < NumRandom; n++) begin
			sendInstr(randomInstr());
		end
		inValid <= 1'b0;

		drainResults();
		endRun();
	end

endmodule

//--- verilog/executeUnit.sv
`include "y86_cfg.svh"

module executeUnit (
	input  logic          clk,
	input  logic          rstN,
	input  y86Pkg::icodeE icode,
	input  y86Pkg::fnCode ifun,
	input  y86Pkg::word   valA,
	input  y86Pkg::word   valB,
	input  y86Pkg::word   valC,
	input  logic          ccUpdate,
	output y86Pkg::word   valE,
	output logic          cnd
);

	localparam int Msb = `WORD_WIDTH - 1;

	y86Pkg::condCodes cc;
	y86Pkg::condCodes ccNext;
	y86Pkg::word      aluOut;
	logic             aluOf;

	// opq computes valB op valA, matching the operand order of subq
	always_comb begin
		case (ifun)
			4'h1: begin
				aluOut = valB - valA;
				aluOf  = (valB[Msb] != valA[Msb]) && (aluOut[Msb] != valB[Msb]);
			end
			4'h2: begin
				aluOut = valB & valA;
				aluOf  = 1'b0;
			end
			4'h3: begin
				aluOut = valB ^ valA;
				aluOf  = 1'b0;
			end
			default: begin
				aluOut = valB + valA;
				aluOf  = (valB[Msb] == valA[Msb]) && (aluOut[Msb] != valB[Msb]);
			end
		endcase
	end

	always_comb begin
		case (icode)
			y86Pkg::icIrmovq: valE = valC;
			y86Pkg::icRrmovq: valE = valA;
			y86Pkg::icRmmovq,
			y86Pkg::icMrmovq: valE = valB + valC;
			y86Pkg::icOpq:    valE = aluOut;
			y86Pkg::icCall,
			y86Pkg::icPushq:  valE = valB - 64'd8;
			y86Pkg::icRet,
			y86Pkg::icPopq:   valE = valB + 64'd8;
			default:          valE = '0;
		endcase
	end

	// jXX and cmovXX share the seven Y86 conditions
	always_comb begin
		case (ifun)
			4'h0:    cnd = 1'b1;
			4'h1:    cnd = (cc.sf ^ cc.of) | cc.zf;
			4'h2:    cnd = cc.sf ^ cc.of;
			4'h3:    cnd = cc.zf;
			4'h4:    cnd = ~cc.zf;
			4'h5:    cnd = ~(cc.sf ^ cc.of);
			4'h6:    cnd = ~(cc.sf ^ cc.of) & ~cc.zf;
			default: cnd = 1'b0;
		endcase
	end

	assign ccNext.zf = (aluOut == '0);
	assign ccNext.sf = aluOut[Msb];
	assign ccNext.of = aluOf;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			cc <= '{zf: 1'b1, sf: 1'b0, of: 1'b0};
		end else if (ccUpdate) begin
			cc <= ccNext;
		end
	end

endmodule

//--- verilog/regIdSelect.sv
`include "y86_cfg.svh"

module regIdSelect (
	input  y86Pkg::icodeE icode,
	input  y86Pkg::fnCode ifun,
	input  y86Pkg::regId  rA,
	input  y86Pkg::regId  rB,
	input  logic          cnd,
	output y86Pkg::regId  srcA,
	output y86Pkg::regId  srcB,
	output y86Pkg::regId  dstE,
	output y86Pkg::regId  dstM
);

	// first read port supplies the data operand or the stack pointer for ret/popq
	always_comb begin
		case (icode)
			y86Pkg::icRrmovq,
			y86Pkg::icRmmovq,
			y86Pkg::icOpq,
			y86Pkg::icPushq: srcA = rA;
			y86Pkg::icRet,
			y86Pkg::icPopq:  srcA = `REG_RSP;
			default:         srcA = `REG_NONE;
		endcase
	end

	// second read port is the base register or the stack pointer
	always_comb begin
		case (icode)
			y86Pkg::icRmmovq,
			y86Pkg::icMrmovq,
			y86Pkg::icOpq:   srcB = rB;
			y86Pkg::icCall,
			y86Pkg::icRet,
			y86Pkg::icPushq,
			y86Pkg::icPopq:  srcB = `REG_RSP;
			default:         srcB = `REG_NONE;
		endcase
	end

	always_comb begin
		case (icode)
			y86Pkg::icRrmovq: begin
				// a conditional move that fails writes nothing
				if (ifun == 4'h0 || cnd) begin
					dstE = rB;
				end else begin
					dstE = `REG_NONE;
				end
			end
			y86Pkg::icIrmovq,
			y86Pkg::icOpq:   dstE = rB;
			y86Pkg::icCall,
			y86Pkg::icRet,
			y86Pkg::icPushq,
			y86Pkg::icPopq:  dstE = `REG_RSP;
			default:         dstE = `REG_NONE;
		endcase
	end

	always_comb begin
		case (icode)
			y86Pkg::icMrmovq,
			y86Pkg::icPopq:  dstM = rA;
			default:         dstM = `REG_NONE;
		endcase
	end

endmodule

//--- verilog/registerFile.sv
`include "y86_cfg.svh"

module registerFile (
	input  logic         clk,
	input  logic         rstN,
	input  y86Pkg::regId srcA,
	input  y86Pkg::regId srcB,
	output y86Pkg::word  valA,
	output y86Pkg::word  valB,
	input  y86Pkg::regId dstE,
	input  y86Pkg::regId dstM,
	input  y86Pkg::word  valE,
	input  y86Pkg::word  valM,
	input  logic         wrEn
);

	y86Pkg::word regs [`NUM_REGS];

	// the none ID reads as zero since it has no storage behind it
	assign valA = (srcA == `REG_NONE) ? '0 : regs[srcA];
	assign valB = (srcB == `REG_NONE) ? '0 : regs[srcB];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			if (dstE != `REG_NONE) begin
				regs[dstE] <= valE;
			end
			// port M comes last so it wins on popq %rsp
			if (dstM != `REG_NONE) begin
				regs[dstM] <= valM;
			end
		end
	end

endmodule

//--- verilog/y86DecodeExecute.sv
module y86DecodeExecute (
	input  logic             clk,
	input  logic             rstN,
	input  logic             inValid,
	output logic             inReady,
	input  y86Pkg::instrRec  inInstr,
	output logic             outValid,
	input  logic             outReady,
	output y86Pkg::resultRec outResult
);

	logic             exValid;
	y86Pkg::instrRec  exInstr;
	logic             resValid;
	y86Pkg::resultRec resRec;

	logic         moveEx;
	logic         accept;
	y86Pkg::regId srcA;
	y86Pkg::regId srcB;
	y86Pkg::regId dstE;
	y86Pkg::regId dstM;
	y86Pkg::word  valA;
	y86Pkg::word  valB;
	y86Pkg::word  valE;
	logic         cnd;

	// the execute slot advances when the result slot is free or drains this cycle
	assign moveEx  = exValid && (!resValid || outReady);
	assign inReady = !exValid || moveEx;
	assign accept  = inValid && inReady;

	assign outValid  = resValid;
	assign outResult = resRec;

	regIdSelect uRegIdSelect (
		.icode (exInstr.icode),
		.ifun  (exInstr.ifun),
		.rA    (exInstr.rA),
		.rB    (exInstr.rB),
		.cnd   (cnd),
		.srcA  (srcA),
		.srcB  (srcB),
		.dstE  (dstE),
		.dstM  (dstM)
	);

	// registers and flags only change on the edge the slot moves on
	registerFile uRegisterFile (
		.clk  (clk),
		.rstN (rstN),
		.srcA (srcA),
		.srcB (srcB),
		.valA (valA),
		.valB (valB),
		.dstE (dstE),
		.dstM (dstM),
		.valE (valE),
		.valM (exInstr.valM),
		.wrEn (moveEx)
	);

	executeUnit uExecuteUnit (
		.clk      (clk),
		.rstN     (rstN),
		.icode    (exInstr.icode),
		.ifun     (exInstr.ifun),
		.valA     (valA),
		.valB     (valB),
		.valC     (exInstr.valC),
		.ccUpdate (moveEx && exInstr.icode == y86Pkg::icOpq),
		.valE     (valE),
		.cnd      (cnd)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exValid  <= 1'b0;
			resValid <= 1'b0;
		end else begin
			if (accept) begin
				exValid <= 1'b1;
			end else if (moveEx) begin
				exValid <= 1'b0;
			end
			if (moveEx) begin
				resValid <= 1'b1;
			end else if (outReady) begin
				resValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			exInstr <= inInstr;
		end
		if (moveEx) begin
			resRec <= '{icode: exInstr.icode, cnd: cnd, valE: valE, valA: valA};
		end
	end

endmodule

//--- vlog.f
+incdir+common
common/y86Pkg.sv
verilog/regIdSelect.sv
verilog/registerFile.sv
verilog/executeUnit.sv
verilog/y86DecodeExecute.sv
test/y86Checker.sv
test/y86Tb.sv
